//--- compile.f
+incdir+hw
hw/xbar_pkg.sv
hw/setting_reg.sv
hw/axi_fifo_short.sv
hw/pkt_present_mon.sv
hw/axi_crossbar.sv
hw/xbar_top.sv
verification/xbar_tb.sv

//--- hw/axi_crossbar.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet crossbar: routing table lookup on DST, round-robin arbiter
// and whole-packet switching on every output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "xbar_params.svh"

module axi_crossbar (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  logic                    i_clear,
   input  logic [7:0]              i_local_addr,
   input  xbar_pkg::set_bus_t      i_set,
   input  logic [`NUM_INPUTS-1:0]  i_pkt_present,
   // From the input FIFOs
   input  xbar_pkg::stream_beat_t  i_beat [`NUM_INPUTS],
   input  logic [`NUM_INPUTS-1:0]  i_valid,
   output logic [`NUM_INPUTS-1:0]  o_ready,
   // To the output FIFOs
   output xbar_pkg::stream_beat_t  o_beat [`NUM_OUTPUTS],
   output logic [`NUM_OUTPUTS-1:0] o_valid,
   input  logic [`NUM_OUTPUTS-1:0] i_ready
);

   localparam int HALF_W      = `DST_WIDTH / 2;
   localparam int TBL_IDX_W   = HALF_W + 1;
   localparam int TBL_ENTRIES = 2 ** TBL_IDX_W;
   localparam int IN_W        = (`NUM_INPUTS > 1) ? $clog2(`NUM_INPUTS) : 1;

   logic [`OUT_SEL_WIDTH-1:0] route_tbl [TBL_ENTRIES];
   logic                      tbl_wr;
   logic [`SR_AWIDTH-1:0]     tbl_off;
   logic [TBL_IDX_W-1:0]      tbl_idx [`NUM_INPUTS];
   logic [`OUT_SEL_WIDTH-1:0] in_dest [`NUM_INPUTS];
   logic [`NUM_INPUTS-1:0]    out_req [`NUM_OUTPUTS];
   logic [`NUM_OUTPUTS-1:0]   out_busy;
   logic [IN_W-1:0]           out_grant [`NUM_OUTPUTS];

   // Table writes land in the window above SR_XB_TABLE
   assign tbl_off = i_set.addr - `SR_AWIDTH'(`SR_XB_TABLE);
   assign tbl_wr  = i_set.stb && (i_set.addr >= `SR_XB_TABLE) && (tbl_off < TBL_ENTRIES);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int e = 0; e < TBL_ENTRIES; e++) begin
            route_tbl[e] <= '0;
         end
      end else if (tbl_wr) begin
         route_tbl[tbl_off[TBL_IDX_W-1:0]] <= i_set.data[`OUT_SEL_WIDTH-1:0];
      end
   end

   // Per input: decode the head beat and request its output
   for (genvar m = 0; m < `NUM_INPUTS; m++) begin : g_in
      logic [`DST_WIDTH-1:0] dst;
      logic                  busy;
      logic                  rdy;

      assign dst = i_beat[m].data[`DST_WIDTH-1:0];

      // Local packets use the upper half of the table, by DST low byte
      assign tbl_idx[m] = (dst[`DST_WIDTH-1:HALF_W] == i_local_addr) ?
                          {1'b1, dst[HALF_W-1:0]} :
                          {1'b0, dst[`DST_WIDTH-1:HALF_W]};
      assign in_dest[m] = route_tbl[tbl_idx[m]];

      // Busy while some output holds a grant for this input
      always_comb begin
         busy = 1'b0;
         rdy  = 1'b0;
         for (int n = 0; n < `NUM_OUTPUTS; n++) begin
            if (out_busy[n] && (out_grant[n] == m)) begin
               busy = 1'b1;
               rdy  = i_ready[n];
            end
         end
      end

      assign o_ready[m] = rdy;

      for (genvar n = 0; n < `NUM_OUTPUTS; n++) begin : g_req
         assign out_req[n][m] = i_pkt_present[m] && !busy && (in_dest[m] == n);
      end
   end

   // Per output: round-robin arbiter with a grant held for one packet
   for (genvar n = 0; n < `NUM_OUTPUTS; n++) begin : g_out
      logic            busy;
      logic [IN_W-1:0] grant;
      logic [IN_W-1:0] last_served;
      logic            found;
      logic [IN_W-1:0] sel;
      logic            pkt_done;

      // Search starts just after the last input served
      always_comb begin
         int cand;
         found = 1'b0;
         sel   = last_served;
         for (int k = 1; k <= `NUM_INPUTS; k++) begin
            cand = (int'(last_served) + k) % `NUM_INPUTS;
            if (!found && out_req[n][cand]) begin
               found = 1'b1;
               sel   = IN_W'(cand);
            end
         end
      end

      assign pkt_done = o_valid[n] && i_ready[n] && o_beat[n].last;

      always_ff @(posedge clk or negedge i_rst_n) begin
         if (!i_rst_n) begin
            busy        <= 1'b0;
            grant       <= '0;
            last_served <= IN_W'(`NUM_INPUTS - 1);
         end else if (i_clear) begin
            busy        <= 1'b0;
            grant       <= '0;
            last_served <= IN_W'(`NUM_INPUTS - 1);
         end else if (!busy) begin
            if (found) begin
               busy        <= 1'b1;
               grant       <= sel;
               last_served <= sel;
            end
         end else if (pkt_done) begin
            busy <= 1'b0;
         end
      end

      assign out_busy[n]  = busy;
      assign out_grant[n] = grant;

      // Granted input passes straight through until its last beat
      assign o_beat[n]  = i_beat[grant];
      assign o_valid[n] = busy && i_valid[grant];
   end

endmodule

//--- hw/axi_fifo_short.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Short stream FIFO: circular buffer with valid/ready on both sides
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "xbar_params.svh"

module axi_fifo_short #(
   parameter type T = xbar_pkg::stream_beat_t
) (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_clear,
   // Write side
   input  T     i_data,
   input  logic i_valid,
   output logic o_ready,
   // Read side
   output T     o_data,
   output logic o_valid,
   input  logic i_ready
);

   localparam int AW    = `FIFO_DEPTH_LOG2;
   localparam int DEPTH = 2 ** AW;

   T               mem [DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [AW:0]    count;
   logic           do_wr;
   logic           do_rd;

   assign o_ready = (count != DEPTH[AW:0]);
   assign o_valid = (count != '0);
   assign o_data  = mem[rd_ptr];

   assign do_wr = i_valid && o_ready;
   assign do_rd = o_valid && i_ready;

   // Storage only, pointers below decide what is valid
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else if (i_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous read and write leaves the count alone
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- hw/pkt_present_mon.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet monitor: counts whole packets held in a FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pkt_present_mon #(
   parameter int COUNT_BITS = 8
) (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_clear,
   // Last beat accepted by the FIFO
   input  logic i_in_xfer_last,
   // Last beat taken from the FIFO
   input  logic i_out_xfer_last,
   output logic o_pkt_present
);

   logic [COUNT_BITS-1:0] pkt_count;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pkt_count <= '0;
      end else if (i_clear) begin
         pkt_count <= '0;
      end else begin
         case ({i_in_xfer_last, i_out_xfer_last})
            2'b10:   pkt_count <= pkt_count + 1'b1;
            2'b01:   pkt_count <= pkt_count - 1'b1;
            default: pkt_count <= pkt_count;
         endcase
      end
   end

   assign o_pkt_present = (pkt_count != '0);

endmodule

//--- hw/setting_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Settings register: loads from the settings bus on its own address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module setting_reg #(
   parameter int MY_ADDR = 0,
   parameter int WIDTH   = 32
) (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  xbar_pkg::set_bus_t   i_set,
   output logic [WIDTH-1:0]     o_value,
   output logic                 o_changed
);

   logic hit;

   assign hit = i_set.stb && (i_set.addr == MY_ADDR);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_value   <= '0;
         o_changed <= 1'b0;
      end else begin
         // Pulse follows every load, even if the value is unchanged
         o_changed <= hit;
         if (hit) begin
            o_value <= i_set.data[WIDTH-1:0];
         end
      end
   end

endmodule

//--- hw/xbar_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossbar parameters: stream widths, port counts, FIFO depth and
// settings bus addresses for the packet router
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

// Data bits per stream beat
`define STREAM_WIDTH 64

// Port counts
`define NUM_INPUTS 2
`define NUM_OUTPUTS 2

// Routing field in the low bits of the first beat
`define DST_WIDTH 16

// Short FIFOs hold 16 entries
`define FIFO_DEPTH_LOG2 4

// Settings bus
`define SR_AWIDTH 16
`define SR_XB_LOCAL 512
// Remote entries 0..255 by DST[15:8], local entries 256..511 by DST[7:0]
`define SR_XB_TABLE 1024

// One table entry selects an output port
`define OUT_SEL_WIDTH 1

`endif

//--- hw/xbar_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossbar types: stream beat and settings bus structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "xbar_params.svh"

package xbar_pkg;

   // One beat of a stream, last marks the end of a packet
   typedef struct packed {
      logic                     last;
      logic [`STREAM_WIDTH-1:0] data;
   } stream_beat_t;

   // Settings bus write, one strobe per write
   typedef struct packed {
      logic                  stb;
      logic [`SR_AWIDTH-1:0] addr;
      logic [31:0]           data;
   } set_bus_t;

endpackage

//--- hw/xbar_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossbar top: input FIFOs with packet monitors, the crossbar and
// output FIFOs, with the local address held in a settings register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "xbar_params.svh"

module xbar_top (
   input  logic                    clk,
   input  logic                    i_rst_n,
   input  logic                    i_clear,
   input  xbar_pkg::set_bus_t      i_set,
   input  xbar_pkg::stream_beat_t  i_in_beat [`NUM_INPUTS],
   input  logic [`NUM_INPUTS-1:0]  i_in_valid,
   output logic [`NUM_INPUTS-1:0]  o_in_ready,
   output xbar_pkg::stream_beat_t  o_out_beat [`NUM_OUTPUTS],
   output logic [`NUM_OUTPUTS-1:0] o_out_valid,
   input  logic [`NUM_OUTPUTS-1:0] i_out_ready
);

   logic [7:0]                     local_addr;
   xbar_pkg::stream_beat_t         in_fifo_beat [`NUM_INPUTS];
   logic [`NUM_INPUTS-1:0]         in_fifo_valid;
   logic [`NUM_INPUTS-1:0]         xb_in_ready;
   logic [`NUM_INPUTS-1:0]         pkt_present;
   xbar_pkg::stream_beat_t         xb_out_beat [`NUM_OUTPUTS];
   logic [`NUM_OUTPUTS-1:0]        xb_out_valid;
   logic [`NUM_OUTPUTS-1:0]        out_fifo_ready;

   setting_reg #(.MY_ADDR(`SR_XB_LOCAL), .WIDTH(8)) u_sr_local (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_set     (i_set),
      .o_value   (local_addr),
      .o_changed ()
   );

   for (genvar m = 0; m < `NUM_INPUTS; m++) begin : g_in
      axi_fifo_short #(.T(xbar_pkg::stream_beat_t)) u_fifo_in (
         .clk     (clk),
         .i_rst_n (i_rst_n),
         .i_clear (i_clear),
         .i_data  (i_in_beat[m]),
         .i_valid (i_in_valid[m]),
         .o_ready (o_in_ready[m]),
         .o_data  (in_fifo_beat[m]),
         .o_valid (in_fifo_valid[m]),
         .i_ready (xb_in_ready[m])
      );

      // Count can reach the FIFO depth, one bit more than the pointers
      pkt_present_mon #(.COUNT_BITS(`FIFO_DEPTH_LOG2 + 1)) u_mon (
         .clk             (clk),
         .i_rst_n         (i_rst_n),
         .i_clear         (i_clear),
         .i_in_xfer_last  (i_in_valid[m] & o_in_ready[m] & i_in_beat[m].last),
         .i_out_xfer_last (in_fifo_valid[m] & xb_in_ready[m] & in_fifo_beat[m].last),
         .o_pkt_present   (pkt_present[m])
      );
   end

   axi_crossbar u_xbar (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_clear       (i_clear),
      .i_local_addr  (local_addr),
      .i_set         (i_set),
      .i_pkt_present (pkt_present),
      .i_beat        (in_fifo_beat),
      .i_valid       (in_fifo_valid),
      .o_ready       (xb_in_ready),
      .o_beat        (xb_out_beat),
      .o_valid       (xb_out_valid),
      .i_ready       (out_fifo_ready)
   );

   for (genvar n = 0; n < `NUM_OUTPUTS; n++) begin : g_out
      axi_fifo_short #(.T(xbar_pkg::stream_beat_t)) u_fifo_out (
         .clk     (clk),
         .i_rst_n (i_rst_n),
         .i_clear (i_clear),
         .i_data  (xb_out_beat[n]),
         .i_valid (xb_out_valid[n]),
         .o_ready (out_fifo_ready[n]),
         .o_data  (o_out_beat[n]),
         .o_valid (o_out_valid[n]),
         .i_ready (i_out_ready[n])
      );
   end

endmodule

//--- verification/xbar_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Crossbar testbench: sends tagged packets through the router and
// checks routing, packet order, back-pressure and clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "xbar_params.svh"

module xbar_tb;

   localparam int NI = `NUM_INPUTS;
   localparam int NO = `NUM_OUTPUTS;

   logic                   clk;
   logic                   rst_n;
   logic                   clear;
   xbar_pkg::set_bus_t     set_bus;
   xbar_pkg::stream_beat_t in_beat [NI];
   logic [NI-1:0]          in_valid;
   logic [NI-1:0]          in_ready;
   xbar_pkg::stream_beat_t out_beat [NO];
   logic [NO-1:0]          out_valid;
   logic [NO-1:0]          out_ready;

   // Model of the settings written so far
   logic [7:0]             local_addr;
   logic                   tbl [512];
   // Expected output, DST and length per source and sequence number
   int                     exp_out [NI][256];
   logic [15:0]            exp_dst [NI][256];
   int                     exp_len [NI][256];
   bit                     got [NI][256];
   int                     seq_cnt [NI];
   int                     outstanding;
   // Packet in progress on each output
   bit                     in_pkt [NO];
   int                     cur_src [NO];
   int                     cur_seq [NO];
   int                     beat_cnt [NO];
   int                     last_seq [NO][NI];
   bit                     pend_v [NO];
   xbar_pkg::stream_beat_t pend_b [NO];
   bit                     saw_in_full;
   int                     ready_mode;
   logic [15:0]            dst_list [5] = '{16'h3c10, 16'h3c20, 16'h5501, 16'h6602, 16'h3c99};

   xbar_top UUT (
      .clk         (clk),
      .i_rst_n     (rst_n),
      .i_clear     (clear),
      .i_set       (set_bus),
      .i_in_beat   (in_beat),
      .i_in_valid  (in_valid),
      .o_in_ready  (in_ready),
      .o_out_beat  (out_beat),
      .o_out_valid (out_valid),
      .i_out_ready (out_ready)
   );

   always #10 clk = ~clk;

   // 0 always ready, 1 random, 2 stalled
   always @(negedge clk) begin
      case (ready_mode)
         0:       out_ready = '1;
         1:       out_ready = NO'($urandom);
         default: out_ready = '0;
      endcase
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic set_write(input int addr, input int data);
      @(negedge clk);
      set_bus = '{stb: 1'b1, addr: 16'(addr), data: 32'(data)};
      @(negedge clk);
      set_bus.stb = 1'b0;
      if (addr == `SR_XB_LOCAL) local_addr = data[7:0];
      if (addr >= `SR_XB_TABLE && addr < `SR_XB_TABLE + 512) tbl[addr - `SR_XB_TABLE] = data[0];
   endtask

   // Local DST uses entry 256 plus the low byte, remote DST the high byte
   function automatic int route_of(input logic [15:0] dst);
      if (dst[15:8] == local_addr) return int'(tbl[256 + dst[7:0]]);
      return int'(tbl[dst[15:8]]);
   endfunction

   task automatic send_pkt(input int m, input logic [15:0] dst, input int len);
      int seq;
      int waited;
      seq = seq_cnt[m];
      if (seq > 255) stop_run("The test ran out of packet sequence numbers");
      seq_cnt[m]++;
      exp_out[m][seq] = route_of(dst);
      exp_dst[m][seq] = dst;
      exp_len[m][seq] = len;
      outstanding++;
      for (int b = 0; b < len; b++) begin
         @(negedge clk);
         in_beat[m].last = (b == len - 1);
         in_beat[m].data = {24'h0, 8'(b), 8'(seq), 8'(m), dst};
         in_valid[m] = 1'b1;
         waited = 0;
         @(posedge clk);
         while (!in_ready[m]) begin
            waited++;
            if (waited > 500) stop_run($sformatf("Input %0d timed out waiting for ready", m));
            @(posedge clk);
         end
      end
      @(negedge clk);
      in_valid[m] = 1'b0;
   endtask

   // Zero DST or length picks one at random
   task automatic send_burst(input int m, input int count, input logic [15:0] dst, input int len);
      logic [15:0] d;
      int          l;
      for (int i = 0; i < count; i++) begin
         d = (dst != 0) ? dst : dst_list[$urandom_range(4, 0)];
         l = (len != 0) ? len : $urandom_range(8, 1);
         send_pkt(m, d, l);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (outstanding != 0) begin
         waited++;
         if (waited > 3000) stop_run("Timed out waiting for all sent packets to come out");
         @(posedge clk);
      end
   endtask

   task automatic check_beat(input int n, input xbar_pkg::stream_beat_t b);
      int src;
      int seq;
      int idx;
      src = int'(b.data[23:16]);
      seq = int'(b.data[31:24]);
      idx = int'(b.data[39:32]);
      assert (src < NI)
         else stop_run($sformatf("Fail at %0t: output %0d bad source %0d", $time, n, src));
      if (!in_pkt[n]) begin
         assert (exp_out[src][seq] == n && !got[src][seq] && seq > last_seq[n][src])
            else stop_run($sformatf("Fail at %0t: output %0d unexpected packet %0d of input %0d",
                                    $time, n, seq, src));
         in_pkt[n]   = 1'b1;
         cur_src[n]  = src;
         cur_seq[n]  = seq;
         beat_cnt[n] = 0;
      end
      // Interleaving or a lost beat shows up as a tag mismatch
      assert (src == cur_src[n] && seq == cur_seq[n] && idx == beat_cnt[n])
         else stop_run($sformatf("Fail at %0t: output %0d beat out of order", $time, n));
      assert (b.data[15:0] == exp_dst[src][seq] && b.data[63:40] == '0)
         else stop_run($sformatf("Fail at %0t: output %0d beat data corrupted", $time, n));
      assert (b.last == (idx == exp_len[src][seq] - 1))
         else stop_run($sformatf("Fail at %0t: output %0d packet length wrong", $time, n));
      beat_cnt[n]++;
      if (b.last) begin
         got[src][seq]    = 1'b1;
         last_seq[n][src] = seq;
         in_pkt[n]        = 1'b0;
         outstanding--;
      end
   endtask

   always @(posedge clk) begin
      if (rst_n) begin
         for (int n = 0; n < NO; n++) begin
            // A stalled beat must stay put until it transfers
            if (pend_v[n]) begin
               assert (out_valid[n] && out_beat[n] == pend_b[n])
                  else stop_run($sformatf("Fail at %0t: output %0d dropped a beat", $time, n));
            end
            pend_v[n] = out_valid[n] && !out_ready[n] && !clear;
            pend_b[n] = out_beat[n];
            if (out_valid[n] && out_ready[n] && !clear) check_beat(n, out_beat[n]);
         end
         if (in_ready != '1) saw_in_full = 1'b1;
      end
   end

   task automatic clear_traffic();
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      // Stored packets are gone for good
      for (int m = 0; m < NI; m++) begin
         for (int s = 0; s < seq_cnt[m]; s++) begin
            if (!got[m][s]) begin
               got[m][s] = 1'b1;
               outstanding--;
            end
         end
      end
      repeat (4) begin
         @(posedge clk);
         assert (out_valid == '0)
            else stop_run($sformatf("Fail at %0t: output valid after clear", $time));
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      clear       = 1'b0;
      set_bus     = '0;
      in_valid    = '0;
      out_ready   = '1;
      ready_mode  = 0;
      saw_in_full = 1'b0;
      outstanding = 0;
      local_addr  = '0;
      for (int m = 0; m < NI; m++) begin
         in_beat[m] = '0;
         seq_cnt[m] = 0;
         for (int s = 0; s < 256; s++) begin
            exp_out[m][s] = -1;
            exp_dst[m][s] = '0;
            exp_len[m][s] = 0;
            got[m][s]     = 1'b0;
         end
         for (int n = 0; n < NO; n++) last_seq[n][m] = -1;
      end
      for (int n = 0; n < NO; n++) begin
         in_pkt[n] = 1'b0;
         pend_v[n] = 1'b0;
      end
      for (int e = 0; e < 512; e++) tbl[e] = 1'b0;
      void'($urandom(32'h5aebfa4a));
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(posedge clk);
      assert (out_valid == '0 && in_ready == '1)
         else stop_run($sformatf("Fail at %0t: outputs wrong after reset", $time));

      // Local routing by the low byte of DST
      set_write(`SR_XB_LOCAL, 'h3c);
      set_write(`SR_XB_TABLE + 256 + 'h10, 1);
      set_write(`SR_XB_TABLE + 'h55, 1);
      fork
         send_burst(0, 4, 16'h3c10, 0);
         send_burst(1, 4, 16'h3c20, 0);
      join
      wait_drain();

      // Remote routing by the high byte, before and after a table change
      for (int pass = 0; pass < 2; pass++) begin
         fork
            send_burst(0, 3, 16'h5501, 0);
            send_burst(1, 3, 16'h6602, 0);
         join
         wait_drain();
         set_write(`SR_XB_TABLE + 'h55, 0);
         set_write(`SR_XB_TABLE + 'h66, 1);
      end

      // Both inputs compete for one output
      fork
         send_burst(0, 6, 16'h3c10, 0);
         send_burst(1, 6, 16'h3c10, 0);
      join
      wait_drain();

      // Outputs stalled for 40 cycles, then random ready
      @(posedge clk);
      ready_mode = 2;
      fork
         send_burst(0, 5, 16'h3c10, 8);
         send_burst(1, 5, 16'h3c20, 8);
         begin
            repeat (40) @(posedge clk);
            ready_mode = 1;
         end
      join
      fork
         send_burst(0, 12, 16'h0, 0);
         send_burst(1, 12, 16'h0, 0);
      join
      wait_drain();

      // Clear with traffic stored, then the same settings again
      @(posedge clk);
      ready_mode = 2;
      fork
         send_burst(0, 2, 16'h0, 0);
         send_burst(1, 2, 16'h0, 0);
      join
      repeat (10) @(negedge clk);
      clear_traffic();
      @(posedge clk);
      ready_mode = 0;
      fork
         send_burst(0, 4, 16'h0, 0);
         send_burst(1, 4, 16'h0, 0);
      join
      wait_drain();

      if (!saw_in_full) begin
         stop_run("Input ready never fell while the outputs were stalled");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule
